//--- cache_bus_adapter.f
source/adapter_pkg.sv
source/meta_if.sv
source/req_queue.sv
source/req_arbiter.sv
source/rtrn_decoder.sv
source/cache_bus_adapter.sv
tb/cache_bus_adapter_assert.sv
tb/tb_cache_bus_adapter.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and judge the run by its log

rm -f sim.log
(verilator --binary --timing --assert -Wno-fatal -f cache_bus_adapter.f \
  --top-module tb_cache_bus_adapter -o sim_cache_bus_adapter \
  && ./obj_dir/sim_cache_bus_adapter) > sim.log 2>&1 \
  || echo "simulation ended with a non-zero status" >> sim.log

cat sim.log
! grep -q "Something failed" sim.log && grep -q "Everything OK" sim.log \
  && echo "RESULT: PASS" \
  || { echo "RESULT: FAIL"; exit 1; }

//--- tb/tb_cache_bus_adapter.sv
/*
 * cache bus adapter testbench
 * directed cache traffic against a bus memory model with a scoreboard
 * on bus requests and cache returns
 */

`timescale 1ns/1ps
`default_nettype none

module tb_cache_bus_adapter;

  localparam int N_TESTS = 5;

  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  size;
    logic        len;
  } rd_req_t;

  typedef struct packed {
    logic [31:0] addr;
    logic [63:0] data;
    logic [7:0]  be;
    logic        id;
  } wr_t;

  logic clk_i = 1'b0;
  logic rst_ni;
  logic icache_req_valid_i, icache_req_ready_o, icache_rtrn_valid_o;
  logic dcache_req_valid_i, dcache_req_ready_o, dcache_rtrn_valid_o;
  adapter_pkg::icache_req_t  icache_req_i;
  adapter_pkg::icache_rtrn_t icache_rtrn_o;
  adapter_pkg::dcache_req_t  dcache_req_i;
  adapter_pkg::dcache_rtrn_t dcache_rtrn_o;
  logic rd_req_valid_o, rd_req_ready_i, rd_id_o;
  logic [31:0] rd_addr_o, wr_addr_o;
  logic [2:0] rd_size_o;
  logic rd_len_o;
  logic rd_valid_i, rd_last_i, rd_id_i;
  logic [63:0] rd_data_i, wr_data_o;
  logic wr_valid_o, wr_ready_i, wr_id_o;
  logic [7:0] wr_be_o;
  logic b_valid_i, b_ready_o, b_id_i;

  logic [31:0] lfsr_q = 32'd84346;
  logic stall_en = 1'b0;
  logic [1:0] ic_tid_q = '0;
  logic [1:0] dc_tid_q = '0;
  string test_name = "reset";
  int cycle = 0;
  int idx;

  // scoreboard queues
  rd_req_t exp_ic_rd[$], exp_dc_rd[$];
  wr_t exp_wr[$];
  adapter_pkg::icache_rtrn_t exp_ic_rtrn[$];
  adapter_pkg::dcache_rtrn_t exp_dc_rtrn[$];
  bit exp_ic_full[$], exp_dc_full[$];

  // bus model state
  logic [31:0] pend_addr[$];
  logic pend_len[$], pend_id[$];
  int b_due[$];
  logic [31:0] cur_addr;
  logic cur_id;
  int beats_left = 0;
  logic ic_exp_d = 1'b0;
  logic dc_exp_d = 1'b0;

  always #10 clk_i = ~clk_i;

  cache_bus_adapter dut_i (.*);

  task automatic report_error(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[62:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return r;
  endfunction

  function automatic logic [63:0] beat_data(input logic [31:0] addr);
    return {addr ^ 32'h5a5a_5a5a, addr};
  endfunction

  task automatic check_icache_rtrn(input string name, input adapter_pkg::icache_rtrn_t exp,
                                   input adapter_pkg::icache_rtrn_t act, input bit full);
    if (exp.tid !== act.tid || exp.data[63:0] !== act.data[63:0] ||
        (full && exp.data !== act.data)) begin
      report_error($sformatf("error %s: icache return expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_dcache_rtrn(input string name, input adapter_pkg::dcache_rtrn_t exp,
                                   input adapter_pkg::dcache_rtrn_t act, input bit full);
    if (exp.rtype !== act.rtype || exp.tid !== act.tid || exp.data[63:0] !== act.data[63:0] ||
        (full && exp.data !== act.data)) begin
      report_error($sformatf("error %s: dcache return expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_read_req(input string name, input rd_req_t exp, input rd_req_t act);
    if (exp !== act) begin
      report_error($sformatf("error %s: read request expected %h, actual %h", name, exp, act));
    end
  endtask

  task automatic check_write(input string name, input wr_t exp, input wr_t act);
    if (exp !== act) begin
      report_error($sformatf("error %s: bus write expected %h, actual %h", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus memory model
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    rd_req_ready_i <= stall_en ? rand_bits(1) : 1'b1;
    wr_ready_i <= stall_en ? rand_bits(1) : 1'b1;
    rd_valid_i <= 1'b0;
    rd_last_i <= 1'b0;
    if (rst_ni && rd_req_valid_o && rd_req_ready_i) begin
      if (rd_id_o ? exp_dc_rd.size() == 0 : exp_ic_rd.size() == 0) begin
        report_error("bus read request that no cache asked for");
      end
      check_read_req(test_name, rd_id_o ? exp_dc_rd.pop_front() : exp_ic_rd.pop_front(),
                     {rd_addr_o, rd_size_o, rd_len_o});
      pend_addr.push_back(rd_addr_o);
      pend_len.push_back(rd_len_o);
      pend_id.push_back(rd_id_o);
    end
    // one burst at a time keeps each id in order
    if (beats_left == 0 && pend_addr.size() > 0) begin
      cur_addr = pend_addr.pop_front();
      beats_left = pend_len.pop_front() + 1;
      cur_id = pend_id.pop_front();
    end
    if (beats_left > 0) begin
      beats_left = beats_left - 1;
      rd_valid_i <= 1'b1;
      rd_data_i <= beat_data(cur_addr);
      rd_id_i <= cur_id;
      rd_last_i <= (beats_left == 0);
      cur_addr = cur_addr + 32'd8;
    end
    if (rst_ni && wr_valid_o && wr_ready_i) begin
      if (exp_wr.size() == 0) begin
        report_error("bus write that no store asked for");
      end
      check_write(test_name, exp_wr.pop_front(), {wr_addr_o, wr_data_o, wr_be_o, wr_id_o});
      b_due.push_back(cycle + 2);
    end
    if (b_valid_i && b_ready_o) begin
      b_valid_i <= 1'b0;
    end else if (!b_valid_i && b_due.size() > 0 && b_due[0] <= cycle) begin
      void'(b_due.pop_front());
      b_valid_i <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // return monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    ic_exp_d <= rd_valid_i && rd_last_i && !rd_id_i;
    dc_exp_d <= (rd_valid_i && rd_last_i && rd_id_i) || (b_valid_i && b_ready_o);
    if (icache_rtrn_valid_o !== ic_exp_d) begin
      report_error("icache return valid was not one cycle after the last read beat");
    end
    if (dcache_rtrn_valid_o !== dc_exp_d) begin
      report_error("dcache return valid was not one cycle after its bus response");
    end
    if (icache_rtrn_valid_o) begin
      if (exp_ic_rtrn.size() == 0) begin
        report_error("icache return with no request waiting for it");
      end
      check_icache_rtrn(test_name, exp_ic_rtrn.pop_front(), icache_rtrn_o,
                        exp_ic_full.pop_front());
    end
    if (dcache_rtrn_valid_o) begin
      // loads and stores keep their own order
      idx = -1;
      for (int i = exp_dc_rtrn.size() - 1; i >= 0; i--) begin
        if (exp_dc_rtrn[i].rtype == dcache_rtrn_o.rtype) idx = i;
      end
      if (idx < 0) begin
        report_error("dcache return of a kind that no request waits for");
      end
      check_dcache_rtrn(test_name, exp_dc_rtrn[idx], dcache_rtrn_o, exp_dc_full[idx]);
      exp_dc_rtrn.delete(idx);
      exp_dc_full.delete(idx);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // request drivers and tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_icache(input logic [31:0] addr, input logic nc);
    adapter_pkg::icache_req_t req;
    adapter_pkg::icache_rtrn_t exp;
    req.paddr = addr;
    req.nc = nc;
    req.tid = ic_tid_q;
    ic_tid_q = ic_tid_q + 1'b1;
    exp.tid = req.tid;
    exp.data = nc ? {64'h0, beat_data(addr)} : {beat_data(addr + 32'd8), beat_data(addr)};
    exp_ic_rd.push_back({addr, adapter_pkg::MAX_SIZE, !nc});
    exp_ic_rtrn.push_back(exp);
    exp_ic_full.push_back(!nc);
    @(posedge clk_i);
    icache_req_valid_i <= 1'b1;
    icache_req_i <= req;
    do @(posedge clk_i); while (!icache_req_ready_o);
    icache_req_valid_i <= 1'b0;
  endtask

  task automatic send_dcache(input logic store, input logic [2:0] size,
                             input logic [31:0] addr, input logic [63:0] data);
    adapter_pkg::dcache_req_t req;
    adapter_pkg::dcache_rtrn_t exp;
    logic line;
    line = size[2];
    req.rtype = store ? adapter_pkg::DCACHE_STORE : adapter_pkg::DCACHE_LOAD;
    req.size = size;
    req.paddr = addr;
    req.data = data;
    req.tid = dc_tid_q;
    dc_tid_q = dc_tid_q + 1'b1;
    exp.tid = req.tid;
    if (store) begin
      exp.rtype = adapter_pkg::DCACHE_STORE_ACK;
      exp.data = '0;
      exp_wr.push_back({addr, data, 8'(((16'd1 << (1 << size[1:0])) - 1) << addr[2:0]),
                        adapter_pkg::DCACHE_ID});
    end else begin
      exp.rtype = adapter_pkg::DCACHE_LOAD_ACK;
      exp.data = line ? {beat_data(addr + 32'd8), beat_data(addr)} : {64'h0, beat_data(addr)};
      exp_dc_rd.push_back({addr, line ? adapter_pkg::MAX_SIZE : size, line});
    end
    exp_dc_rtrn.push_back(exp);
    exp_dc_full.push_back(store || line);
    @(posedge clk_i);
    dcache_req_valid_i <= 1'b1;
    dcache_req_i <= req;
    do @(posedge clk_i); while (!dcache_req_ready_o);
    dcache_req_valid_i <= 1'b0;
  endtask

  task automatic random_store(input logic [31:0] base);
    logic [1:0] sz;
    logic [2:0] off;
    sz = rand_bits(2);
    off = rand_bits(3) & ~((3'd1 << sz) - 3'd1);
    send_dcache(1'b1, {1'b0, sz}, base | off, rand_bits(64));
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (exp_ic_rtrn.size() || exp_dc_rtrn.size() || exp_wr.size() || beats_left ||
           b_valid_i || b_due.size()) begin
      @(posedge clk_i);
      n++;
      if (n > 300) report_error($sformatf("%s did not finish, returns are missing", test_name));
    end
  endtask

  initial begin
    #(N_TESTS * 400 * 20);
    report_error("timeout: the tests did not complete in time");
  end

  initial begin
    rst_ni = 1'b0;
    icache_req_valid_i = 1'b0;
    icache_req_i = '0;
    dcache_req_valid_i = 1'b0;
    dcache_req_i = '0;
    rd_req_ready_i = 1'b1;
    rd_valid_i = 1'b0;
    rd_data_i = '0;
    rd_last_i = 1'b0;
    rd_id_i = 1'b0;
    wr_ready_i = 1'b1;
    b_valid_i = 1'b0;
    b_id_i = adapter_pkg::DCACHE_ID;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    test_name = "icache_line";
    send_icache(32'h0000_1000, 1'b0);
    wait_idle();
    test_name = "icache_nc";
    send_icache(32'h0000_2008, 1'b1);
    wait_idle();
    test_name = "dcache_loads";
    send_dcache(1'b0, 3'b100, 32'h0000_3000, '0);
    send_dcache(1'b0, 3'd2, 32'h0000_3104, '0);
    wait_idle();
    test_name = "stores";
    repeat (6) random_store(32'h0000_4000);
    wait_idle();
    test_name = "mixed";
    stall_en = 1'b1;
    fork
      for (int i = 0; i < 4; i++) send_icache(32'h0000_5000 + 32'(i * 16), 1'(i % 2));
      for (int i = 0; i < 4; i++) begin
        if (i % 2) random_store(32'h0000_6000 + 32'(i * 8));
        else send_dcache(1'b0, 3'(i * 2), 32'h0000_7000 + 32'(i * 16), '0);
      end
    join
    wait_idle();
    stall_en = 1'b0;
    $display("Everything OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/cache_bus_adapter_assert.sv
/*
 * cache bus adapter assertions
 * bus handshake stability, quiet returns after reset and queue
 * overflow and underflow
 */

`timescale 1ns/1ps
`default_nettype none

module cache_bus_adapter_assert (
  input wire logic clk_i,
  input wire logic rst_ni,
  input wire logic rd_req_valid_o,
  input wire logic rd_req_ready_i,
  input wire logic [adapter_pkg::ADDR_W+adapter_pkg::SIZE_W+adapter_pkg::LEN_W:0] rd_payload_i,
  input wire logic wr_valid_o,
  input wire logic wr_ready_i,
  input wire logic [adapter_pkg::ADDR_W+adapter_pkg::DATA_W+adapter_pkg::BE_W-1:0] wr_payload_i,
  input wire logic icache_rtrn_valid_o,
  input wire logic dcache_rtrn_valid_o,
  input wire logic [4:0] push_i,
  input wire logic [4:0] full_i,
  input wire logic [4:0] pop_i,
  input wire logic [4:0] empty_i
);

  // valid and payload hold until the handshake
  rd_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_req_valid_o && !rd_req_ready_i |=> rd_req_valid_o && $stable(rd_payload_i))
    else $error("bus read request changed before ready");

  wr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wr_valid_o && !wr_ready_i |=> wr_valid_o && $stable(wr_payload_i))
    else $error("bus write changed before ready");

  quiet_after_reset: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> !icache_rtrn_valid_o && !dcache_rtrn_valid_o)
    else $error("return valid high right after reset");

  no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (push_i & full_i) == '0)
    else $error("queue pushed while full");

  no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pop_i & empty_i) == '0)
    else $error("queue popped while empty");

endmodule

// bits from the top are the icache and dcache request queues, then the
// icache read, dcache read and dcache write id queues
bind cache_bus_adapter cache_bus_adapter_assert u_assert (
  .clk_i, .rst_ni,
  .rd_req_valid_o, .rd_req_ready_i,
  .rd_payload_i({rd_addr_o, rd_size_o, rd_len_o, rd_id_o}),
  .wr_valid_o, .wr_ready_i,
  .wr_payload_i({wr_addr_o, wr_data_o, wr_be_o}),
  .icache_rtrn_valid_o, .dcache_rtrn_valid_o,
  .push_i({icache_req_valid_i && icache_req_ready_o, dcache_req_valid_i && dcache_req_ready_o,
           meta.icache_rd_push, meta.dcache_rd_push, meta.dcache_wr_push}),
  .full_i({icache_full, dcache_full,
           meta.icache_rd_full, meta.dcache_rd_full, meta.dcache_wr_full}),
  .pop_i({icache_pop, dcache_pop,
          i_decoder.ic_done, i_decoder.dc_done, i_decoder.b_take}),
  .empty_i({icache_empty, dcache_empty, i_decoder.i_ic_rd_id.empty_o,
            i_decoder.i_dc_rd_id.empty_o, i_decoder.i_dc_wr_id.empty_o})
);

`default_nettype wire

//--- source/cache_bus_adapter.sv
/*
 * cache bus adapter
 * queues requests from the instruction and data caches, arbitrates
 * them onto a split read/write memory bus and sends the responses
 * back to the caches as one-cycle returns
 */

`timescale 1ns/1ps
`default_nettype none

module cache_bus_adapter (
  input  wire logic                            clk_i,
  input  wire logic                            rst_ni,
  // instruction cache
  input  wire logic                            icache_req_valid_i,
  output logic                                 icache_req_ready_o,
  input  wire adapter_pkg::icache_req_t        icache_req_i,
  output logic                                 icache_rtrn_valid_o,
  output adapter_pkg::icache_rtrn_t            icache_rtrn_o,
  // data cache
  input  wire logic                            dcache_req_valid_i,
  output logic                                 dcache_req_ready_o,
  input  wire adapter_pkg::dcache_req_t        dcache_req_i,
  output logic                                 dcache_rtrn_valid_o,
  output adapter_pkg::dcache_rtrn_t            dcache_rtrn_o,
  // bus read request
  output logic                                 rd_req_valid_o,
  input  wire logic                            rd_req_ready_i,
  output logic      [adapter_pkg::ADDR_W-1:0]  rd_addr_o,
  output logic      [adapter_pkg::SIZE_W-1:0]  rd_size_o,
  output logic      [adapter_pkg::LEN_W-1:0]   rd_len_o,
  output logic                                 rd_id_o,
  // bus read data, always accepted
  input  wire logic                            rd_valid_i,
  input  wire logic [adapter_pkg::DATA_W-1:0]  rd_data_i,
  input  wire logic                            rd_last_i,
  input  wire logic                            rd_id_i,
  // bus write
  output logic                                 wr_valid_o,
  input  wire logic                            wr_ready_i,
  output logic      [adapter_pkg::ADDR_W-1:0]  wr_addr_o,
  output logic      [adapter_pkg::DATA_W-1:0]  wr_data_o,
  output logic      [adapter_pkg::BE_W-1:0]    wr_be_o,
  output logic                                 wr_id_o,
  // bus write response
  input  wire logic                            b_valid_i,
  output logic                                 b_ready_o,
  input  wire logic                            b_id_i
);

  adapter_pkg::icache_req_t icache_head;
  adapter_pkg::dcache_req_t dcache_head;
  logic icache_full, icache_empty, icache_pop;
  logic dcache_full, dcache_empty, dcache_pop;

  meta_if meta ();

  assign icache_req_ready_o = !icache_full;
  assign dcache_req_ready_o = !dcache_full;

  req_queue #(.WIDTH($bits(adapter_pkg::icache_req_t)), .DEPTH(adapter_pkg::REQ_DEPTH)) i_ic_q (
    .clk_i, .rst_ni, .push_i(icache_req_valid_i && icache_req_ready_o), .pop_i(icache_pop),
    .data_i(icache_req_i), .data_o(icache_head), .full_o(icache_full), .empty_o(icache_empty)
  );

  req_queue #(.WIDTH($bits(adapter_pkg::dcache_req_t)), .DEPTH(adapter_pkg::REQ_DEPTH)) i_dc_q (
    .clk_i, .rst_ni, .push_i(dcache_req_valid_i && dcache_req_ready_o), .pop_i(dcache_pop),
    .data_i(dcache_req_i), .data_o(dcache_head), .full_o(dcache_full), .empty_o(dcache_empty)
  );

  req_arbiter i_arbiter (
    .clk_i, .rst_ni,
    .icache_req_i(icache_head), .icache_empty_i(icache_empty),
    .dcache_req_i(dcache_head), .dcache_empty_i(dcache_empty),
    .icache_pop_o(icache_pop), .dcache_pop_o(dcache_pop),
    .rd_req_valid_o, .rd_req_ready_i, .rd_addr_o, .rd_size_o, .rd_len_o, .rd_id_o,
    .wr_valid_o, .wr_ready_i, .wr_addr_o, .wr_data_o, .wr_be_o, .wr_id_o,
    .meta(meta.arb)
  );

  rtrn_decoder i_decoder (
    .clk_i, .rst_ni,
    .rd_valid_i, .rd_data_i, .rd_last_i, .rd_id_i,
    .b_valid_i, .b_ready_o, .b_id_i,
    .meta(meta.dec),
    .icache_rtrn_valid_o, .icache_rtrn_o,
    .dcache_rtrn_valid_o, .dcache_rtrn_o
  );

endmodule

`default_nettype wire

//--- source/rtrn_decoder.sv
/*
 * return decoder
 * keeps the cache ids of granted requests, gathers read beats into
 * cache lines and turns write responses into store acknowledges
 */

`timescale 1ns/1ps
`default_nettype none

module rtrn_decoder (
  input  wire logic                              clk_i,
  input  wire logic                              rst_ni,
  input  wire logic                              rd_valid_i,
  input  wire logic [adapter_pkg::DATA_W-1:0]    rd_data_i,
  input  wire logic                              rd_last_i,
  input  wire logic                              rd_id_i,
  input  wire logic                              b_valid_i,
  output logic                                   b_ready_o,
  input  wire logic                              b_id_i,
  meta_if.dec                                    meta,
  output logic                                   icache_rtrn_valid_o,
  output adapter_pkg::icache_rtrn_t              icache_rtrn_o,
  output logic                                   dcache_rtrn_valid_o,
  output adapter_pkg::dcache_rtrn_t              dcache_rtrn_o
);

  logic [adapter_pkg::TID_W-1:0] ic_rd_tid, dc_rd_tid, dc_wr_tid;
  logic ic_beat, dc_beat, ic_done, dc_done, b_take;
  logic ic_first_q, dc_first_q;
  logic ic_valid_q, dc_valid_q;
  logic [adapter_pkg::TID_W-1:0] ic_tid_q, dc_tid_q;
  adapter_pkg::dcache_rtrn_e dc_rtype_q;
  logic [adapter_pkg::LINE_WORDS-1:0][adapter_pkg::DATA_W-1:0] ic_line_q, dc_line_q;

  // a beat shifts in from the top; the first beat of a burst also lands in word 0
  function automatic logic [adapter_pkg::LINE_WORDS-1:0][adapter_pkg::DATA_W-1:0] shift_beat(
    input logic [adapter_pkg::LINE_WORDS-1:0][adapter_pkg::DATA_W-1:0] line,
    input logic [adapter_pkg::DATA_W-1:0] beat,
    input logic first
  );
    logic [adapter_pkg::LINE_WORDS-1:0][adapter_pkg::DATA_W-1:0] res;
    res = {beat, line[adapter_pkg::LINE_WORDS-1:1]};
    if (first) begin
      res[0] = beat;
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // id queues
  ////////////////////////////////////////////////////////////////////////////

  req_queue #(.WIDTH(adapter_pkg::TID_W), .DEPTH(adapter_pkg::META_DEPTH)) i_ic_rd_id (
    .clk_i, .rst_ni, .push_i(meta.icache_rd_push), .pop_i(ic_done), .data_i(meta.tid),
    .data_o(ic_rd_tid), .full_o(meta.icache_rd_full), .empty_o()
  );

  req_queue #(.WIDTH(adapter_pkg::TID_W), .DEPTH(adapter_pkg::META_DEPTH)) i_dc_rd_id (
    .clk_i, .rst_ni, .push_i(meta.dcache_rd_push), .pop_i(dc_done), .data_i(meta.tid),
    .data_o(dc_rd_tid), .full_o(meta.dcache_rd_full), .empty_o()
  );

  req_queue #(.WIDTH(adapter_pkg::TID_W), .DEPTH(adapter_pkg::META_DEPTH)) i_dc_wr_id (
    .clk_i, .rst_ni, .push_i(meta.dcache_wr_push), .pop_i(b_take), .data_i(meta.tid),
    .data_o(dc_wr_tid), .full_o(meta.dcache_wr_full), .empty_o()
  );

  ////////////////////////////////////////////////////////////////////////////
  // beat steering and write responses
  ////////////////////////////////////////////////////////////////////////////

  assign ic_beat = rd_valid_i && (rd_id_i == adapter_pkg::ICACHE_ID);
  assign dc_beat = rd_valid_i && (rd_id_i == adapter_pkg::DCACHE_ID);
  assign ic_done = ic_beat && rd_last_i;
  assign dc_done = dc_beat && rd_last_i;

  // the data return port is busy with a read beat, so B waits a cycle
  assign b_ready_o = !dc_beat;
  assign b_take    = b_valid_i && b_ready_o && (b_id_i == adapter_pkg::DCACHE_ID);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ic_first_q <= 1'b1;
      dc_first_q <= 1'b1;
      ic_valid_q <= 1'b0;
      dc_valid_q <= 1'b0;
    end else begin
      if (ic_beat) ic_first_q <= rd_last_i;
      if (dc_beat) dc_first_q <= rd_last_i;
      ic_valid_q <= ic_done;
      dc_valid_q <= dc_done || b_take;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ic_beat) ic_line_q <= shift_beat(ic_line_q, rd_data_i, ic_first_q);
    if (dc_beat) dc_line_q <= shift_beat(dc_line_q, rd_data_i, dc_first_q);
    if (ic_done) ic_tid_q <= ic_rd_tid;
    if (dc_done) begin
      dc_tid_q   <= dc_rd_tid;
      dc_rtype_q <= adapter_pkg::DCACHE_LOAD_ACK;
    end else if (b_take) begin
      dc_tid_q   <= dc_wr_tid;
      dc_rtype_q <= adapter_pkg::DCACHE_STORE_ACK;
    end
  end

  // returns come straight from the registers
  assign icache_rtrn_valid_o = ic_valid_q;
  assign icache_rtrn_o.tid   = ic_tid_q;
  assign icache_rtrn_o.data  = ic_line_q;

  assign dcache_rtrn_valid_o = dc_valid_q;
  assign dcache_rtrn_o.rtype = dc_rtype_q;
  assign dcache_rtrn_o.tid   = dc_tid_q;
  assign dcache_rtrn_o.data  = (dc_rtype_q == adapter_pkg::DCACHE_STORE_ACK) ? '0 : dc_line_q;

endmodule

`default_nettype wire

//--- source/req_arbiter.sv
/*
 * request arbiter
 * round-robin choice between the instruction and data cache queues,
 * held until the bus handshake, and translation of the chosen request
 * into a bus read or a single-beat bus write
 */

`timescale 1ns/1ps
`default_nettype none

module req_arbiter (
  input  wire logic                                clk_i,
  input  wire logic                                rst_ni,
  input  wire adapter_pkg::icache_req_t            icache_req_i,
  input  wire logic                                icache_empty_i,
  input  wire adapter_pkg::dcache_req_t            dcache_req_i,
  input  wire logic                                dcache_empty_i,
  output logic                                     icache_pop_o,
  output logic                                     dcache_pop_o,
  // bus read request
  output logic                                     rd_req_valid_o,
  input  wire logic                                rd_req_ready_i,
  output logic      [adapter_pkg::ADDR_W-1:0]      rd_addr_o,
  output logic      [adapter_pkg::SIZE_W-1:0]      rd_size_o,
  output logic      [adapter_pkg::LEN_W-1:0]       rd_len_o,
  output logic                                     rd_id_o,
  // bus write
  output logic                                     wr_valid_o,
  input  wire logic                                wr_ready_i,
  output logic      [adapter_pkg::ADDR_W-1:0]      wr_addr_o,
  output logic      [adapter_pkg::DATA_W-1:0]      wr_data_o,
  output logic      [adapter_pkg::BE_W-1:0]        wr_be_o,
  output logic                                     wr_id_o,
  meta_if.arb                                      meta
);

  logic ic_elig, dc_elig, dc_store;
  logic sel, grant, rd_hs, wr_hs, hs;
  logic rr_q, lock_q, lock_idx_q;
  logic [adapter_pkg::BE_W-1:0] be_mask;

  ////////////////////////////////////////////////////////////////////////////
  // selection
  ////////////////////////////////////////////////////////////////////////////

  // a request is only offered when its id queue has room
  assign dc_store = (dcache_req_i.rtype == adapter_pkg::DCACHE_STORE);
  assign ic_elig  = !icache_empty_i && !meta.icache_rd_full;
  assign dc_elig  = !dcache_empty_i &&
                    (dc_store ? !meta.dcache_wr_full : !meta.dcache_rd_full);

  always_comb begin
    if (lock_q) begin
      sel = lock_idx_q;
    end else if (ic_elig && dc_elig) begin
      sel = rr_q;
    end else begin
      sel = dc_elig;
    end
  end

  assign grant          = sel ? dc_elig : ic_elig;
  assign rd_req_valid_o = grant && (!sel || !dc_store);
  assign wr_valid_o     = grant && sel && dc_store;
  assign rd_hs          = rd_req_valid_o && rd_req_ready_i;
  assign wr_hs          = wr_valid_o && wr_ready_i;
  assign hs             = rd_hs || wr_hs;

  assign icache_pop_o = hs && !sel;
  assign dcache_pop_o = hs && sel;

  assign meta.icache_rd_push = rd_hs && !sel;
  assign meta.dcache_rd_push = rd_hs && sel;
  assign meta.dcache_wr_push = wr_hs;
  assign meta.tid            = sel ? dcache_req_i.tid : icache_req_i.tid;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rr_q       <= 1'b0;
      lock_q     <= 1'b0;
      lock_idx_q <= 1'b0;
    end else begin
      // hold the grant while the bus stalls us
      lock_q     <= grant && !hs;
      lock_idx_q <= sel;
      if (hs) begin
        rr_q <= !sel;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // bus request formation
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_id_o = sel ? adapter_pkg::DCACHE_ID : adapter_pkg::ICACHE_ID;
    if (sel) begin
      rd_addr_o = dcache_req_i.paddr;
      if (dcache_req_i.size[adapter_pkg::SIZE_W-1]) begin
        rd_size_o = adapter_pkg::MAX_SIZE;
        rd_len_o  = adapter_pkg::LEN_W'(adapter_pkg::LINE_WORDS - 1);
      end else begin
        rd_size_o = dcache_req_i.size;
        rd_len_o  = '0;
      end
    end else begin
      // instruction fills always use full bus words
      rd_addr_o = icache_req_i.paddr;
      rd_size_o = adapter_pkg::MAX_SIZE;
      rd_len_o  = icache_req_i.nc ? '0 : adapter_pkg::LEN_W'(adapter_pkg::LINE_WORDS - 1);
    end
  end

  // 1, 2, 4 or 8 bytes moved up to the address offset
  always_comb begin
    unique case (dcache_req_i.size[1:0])
      2'd0:    be_mask = adapter_pkg::BE_W'(8'h01);
      2'd1:    be_mask = adapter_pkg::BE_W'(8'h03);
      2'd2:    be_mask = adapter_pkg::BE_W'(8'h0f);
      default: be_mask = adapter_pkg::BE_W'(8'hff);
    endcase
  end

  assign wr_addr_o = dcache_req_i.paddr;
  assign wr_id_o   = adapter_pkg::DCACHE_ID;
  assign wr_be_o   = be_mask << dcache_req_i.paddr[$clog2(adapter_pkg::BE_W)-1:0];
  assign wr_data_o = {(adapter_pkg::DATA_W / $bits(dcache_req_i.data)){dcache_req_i.data}};

endmodule

`default_nettype wire

//--- source/req_queue.sv
/*
 * request queue
 * small circular buffer with full and empty flags, head word read
 * straight from the storage array
 */

`timescale 1ns/1ps
`default_nettype none

module req_queue #(
  parameter int unsigned WIDTH = 8,
  parameter int unsigned DEPTH = 2
) (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  input  wire logic             push_i,
  input  wire logic             pop_i,
  input  wire logic [WIDTH-1:0] data_i,
  output logic      [WIDTH-1:0] data_o,
  output logic                  full_o,
  output logic                  empty_o
);

  logic [DEPTH-1:0][WIDTH-1:0] mem_q;
  logic [$clog2(DEPTH)-1:0]    wr_ptr_q, rd_ptr_q;
  logic [$clog2(DEPTH):0]      cnt_q;

  assign data_o  = mem_q[rd_ptr_q];
  assign full_o  = (cnt_q == DEPTH);
  assign empty_o = (cnt_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop_i) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop keep the count
      if (push_i && !pop_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop_i && !push_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

`default_nettype wire

//--- source/meta_if.sv
/*
 * transaction id side channel
 * the arbiter pushes cache ids when a bus request is granted and the
 * return decoder reports back when its id queues are full
 */

`timescale 1ns/1ps
`default_nettype none

interface meta_if;

  logic                           icache_rd_push;
  logic                           dcache_rd_push;
  logic                           dcache_wr_push;
  logic [adapter_pkg::TID_W-1:0]  tid;

  logic                           icache_rd_full;
  logic                           dcache_rd_full;
  logic                           dcache_wr_full;

  modport arb (
    output icache_rd_push, dcache_rd_push, dcache_wr_push, tid,
    input  icache_rd_full, dcache_rd_full, dcache_wr_full
  );

  modport dec (
    input  icache_rd_push, dcache_rd_push, dcache_wr_push, tid,
    output icache_rd_full, dcache_rd_full, dcache_wr_full
  );

endinterface

`default_nettype wire

//--- source/adapter_pkg.sv
/*
 * adapter package
 * widths, queue depths, bus size codes and the request and return
 * types shared by the instruction and data cache ports of the adapter
 */

`default_nettype none

package adapter_pkg;

  localparam int unsigned ADDR_W     = 32;
  localparam int unsigned DATA_W     = 64;
  localparam int unsigned LINE_W     = 128;
  localparam int unsigned LINE_WORDS = 2;
  localparam int unsigned BE_W       = 8;
  localparam int unsigned TID_W      = 2;
  localparam int unsigned LEN_W      = 1;
  localparam int unsigned SIZE_W     = 3;
  localparam int unsigned REQ_DEPTH  = 2;
  localparam int unsigned META_DEPTH = 4;

  // size code of a full bus word
  localparam logic [SIZE_W-1:0] MAX_SIZE = 3'd3;

  // bus ids that tell the two caches apart
  localparam logic ICACHE_ID = 1'b0;
  localparam logic DCACHE_ID = 1'b1;

  typedef enum logic {DCACHE_LOAD, DCACHE_STORE} dcache_rtype_e;
  typedef enum logic {DCACHE_LOAD_ACK, DCACHE_STORE_ACK} dcache_rtrn_e;

  typedef struct packed {
    logic [ADDR_W-1:0] paddr;
    logic              nc;
    logic [TID_W-1:0]  tid;
  } icache_req_t;

  // size msb set means a whole line
  typedef struct packed {
    dcache_rtype_e     rtype;
    logic [SIZE_W-1:0] size;
    logic [ADDR_W-1:0] paddr;
    logic [DATA_W-1:0] data;
    logic [TID_W-1:0]  tid;
  } dcache_req_t;

  typedef struct packed {
    logic [TID_W-1:0]  tid;
    logic [LINE_W-1:0] data;
  } icache_rtrn_t;

  typedef struct packed {
    dcache_rtrn_e      rtype;
    logic [TID_W-1:0]  tid;
    logic [LINE_W-1:0] data;
  } dcache_rtrn_t;

endpackage

`default_nettype wire
